//--- vlog.f
design/mmu_pkg.sv
design/tlb_reset_machine.sv
design/tlb_ram.sv
design/tlb_lookup.sv
design/mmu_top.sv
tests/tb_clkgen.sv
tests/mmu_chk.sv
tests/mmu_monitor.sv
tests/mmu_tb.sv

//--- run.sh
#!/bin/sh
# Compile the MMU testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module mmu_tb \
	-Mdir obj_dir -o mmu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/mmu_sim +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$log"; then
	echo "FAIL"
	exit 1
fi
if ! grep -q "Test completed successfully" "$log"; then
	echo "FAIL: no result line in $log"
	exit 1
fi
echo "PASS"
exit 0

//--- tests/mmu_tb.sv
/* Testbench top: clock, DUT, monitor, seeded random stimulus for six tests
   and a cycle limit */
`timescale 1ns/100ps

module mmu_tb;

	// Cycles per test, drain included
	localparam int len_boot = 132;
	localparam int len_miss = 132;
	localparam int len_upd = 164;
	localparam int len_perm = 132;
	localparam int len_b2b = 132;
	localparam int len_refill = 210;
	localparam int max_cycles = 8 + 70 + len_boot + len_miss + len_upd + len_perm
		+ len_b2b + len_refill + 100;

	logic clk;
	logic rst;
	logic rst_req;
	logic lookup_valid;
	logic upd_valid;
	logic rsp_valid;
	logic ready;
	logic done;
	mmu_pkg::lookup_req_t lookup_req;
	mmu_pkg::tlb_wr_t upd;
	mmu_pkg::lookup_rsp_t rsp;
	int test_num;
	int err_cnt;
	int cycle_cnt = 0;

	tb_clkgen u_clkgen
	(
		.rst_req (rst_req),
		.clk (clk),
		.rst (rst)
	);

	mmu_top u_mmu_top
	(
		.clk (clk),
		.rst (rst),
		.lookup_valid (lookup_valid),
		.lookup_req (lookup_req),
		.upd_valid (upd_valid),
		.upd (upd),
		.rsp_valid (rsp_valid),
		.rsp (rsp),
		.ready (ready)
	);

	mmu_monitor u_monitor
	(
		.clk (clk),
		.rst (rst),
		.lookup_valid (lookup_valid),
		.lookup_req (lookup_req),
		.upd_valid (upd_valid),
		.upd (upd),
		.rsp_valid (rsp_valid),
		.rsp (rsp),
		.ready (ready),
		.test_num (test_num),
		.done (done),
		.err_cnt (err_cnt)
	);

	function automatic mmu_pkg::va_t make_va(input mmu_pkg::vpn_tag_t tag,
		input mmu_pkg::tlb_idx_t idx);
		logic [12:0] off;
		off = 13'($urandom);
		return {tag, idx, off};
	endfunction

	function automatic mmu_pkg::lookup_req_t make_req(input mmu_pkg::va_t va,
		input mmu_pkg::access_t acc);
		mmu_pkg::lookup_req_t req;
		req.va = va;
		req.acc = acc;
		return req;
	endfunction

	function automatic mmu_pkg::access_t rand_acc();
		return mmu_pkg::access_t'($urandom_range(2, 0));
	endfunction

	function automatic mmu_pkg::tlb_wr_t rand_entry();
		mmu_pkg::tlb_wr_t wr;
		wr.idx = mmu_pkg::tlb_idx_t'($urandom);
		wr.entry.tag = mmu_pkg::vpn_tag_t'($urandom);
		wr.entry.pte.v = 1'b1;
		wr.entry.pte.lvl = mmu_pkg::lvl_t'($urandom);
		wr.entry.pte.rwx = mmu_pkg::rwx_t'($urandom);
		wr.entry.pte.ppn = mmu_pkg::ppn_t'($urandom);
		return wr;
	endfunction

	task automatic drive_cycle(input logic lv, input mmu_pkg::lookup_req_t req,
		input logic uv, input mmu_pkg::tlb_wr_t wr);
		@(posedge clk);
		lookup_valid <= lv;
		lookup_req <= req;
		upd_valid <= uv;
		upd <= wr;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
			drive_cycle(1'b0, '0, 1'b0, '0);
	endtask

	task automatic boot_hits();
		test_num <= 1;
		while (ready !== 1'b1)
			@(posedge clk);
		for (int i = 0; i < 128; i++)
			drive_cycle(1'b1, make_req(make_va('0, mmu_pkg::tlb_idx_t'($urandom_range(127, 64))),
				rand_acc()), 1'b0, '0);
		idle_cycles(4);
	endtask

	task automatic miss_lookups();
		mmu_pkg::va_t va;
		test_num <= 2;
		for (int i = 0; i < 128; i++)
		begin
			if (i[0])
				va = make_va(mmu_pkg::vpn_tag_t'($urandom),
					mmu_pkg::tlb_idx_t'($urandom_range(63, 0)));
			else
				va = make_va(mmu_pkg::vpn_tag_t'($urandom_range(4095, 1)),
					mmu_pkg::tlb_idx_t'($urandom_range(127, 64)));	// Filled, wrong tag
			drive_cycle(1'b1, make_req(va, rand_acc()), 1'b0, '0);
		end
		idle_cycles(4);
	endtask

	task automatic random_updates();
		mmu_pkg::tlb_wr_t wr;
		mmu_pkg::tlb_idx_t idx_list [32];
		mmu_pkg::vpn_tag_t tag_list [32];
		mmu_pkg::va_t va;
		int j;
		test_num <= 3;
		for (int i = 0; i < 32; i++)
		begin
			wr = rand_entry();
			wr.entry.pte.v = ($urandom_range(3, 0) != 0);	// Mostly valid
			idx_list[i] = wr.idx;
			tag_list[i] = wr.entry.tag;
			drive_cycle(1'b0, '0, 1'b1, wr);
		end
		// Three of four lookups aim at an updated tag
		for (int i = 0; i < 128; i++)
		begin
			j = int'($urandom_range(31, 0));
			if ($urandom_range(3, 0) != 0)
				va = make_va(tag_list[j], idx_list[j]);
			else
				va = mmu_pkg::va_t'($urandom);
			drive_cycle(1'b1, make_req(va, rand_acc()), 1'b0, '0);
		end
		idle_cycles(4);
	endtask

	task automatic perm_faults();
		mmu_pkg::tlb_wr_t wr;
		test_num <= 4;
		for (int i = 0; i < 64; i++)
		begin
			wr = rand_entry();
			drive_cycle(1'b0, '0, 1'b1, wr);
			drive_cycle(1'b1, make_req(make_va(wr.entry.tag, wr.idx), rand_acc()), 1'b0, '0);
		end
		idle_cycles(4);
	endtask

	// Few indices and tags so that reads and writes collide often
	task automatic back_to_back();
		mmu_pkg::tlb_wr_t wr;
		mmu_pkg::tlb_idx_t idx;
		mmu_pkg::vpn_tag_t tag;
		test_num <= 5;
		for (int i = 0; i < 128; i++)
		begin
			idx = mmu_pkg::tlb_idx_t'($urandom_range(71, 64));
			tag = mmu_pkg::vpn_tag_t'($urandom_range(3, 0));
			wr = rand_entry();
			wr.idx = idx;
			wr.entry.tag = mmu_pkg::vpn_tag_t'($urandom_range(3, 0));
			wr.entry.pte.v = ($urandom_range(3, 0) != 0);
			drive_cycle(1'b1, make_req(make_va(tag, idx), rand_acc()),
				($urandom_range(1, 0) == 1), wr);
		end
		idle_cycles(4);
	endtask

	task automatic reset_during_fill();
		mmu_pkg::tlb_wr_t wr;
		test_num <= 6;
		rst_req <= 1'b1;
		for (int i = 0; i < 68; i++)
		begin
			wr = rand_entry();
			wr.entry.tag = '0;	// Would hit if it got through
			drive_cycle(1'b0, '0, 1'b1, wr);
			if (i == 7)
				rst_req <= 1'b0;
		end
		drive_cycle(1'b0, '0, 1'b0, '0);
		while (ready !== 1'b1)
			@(posedge clk);
		for (int i = 0; i < 128; i++)
			drive_cycle(1'b1, make_req(make_va('0, mmu_pkg::tlb_idx_t'(i)), rand_acc()),
				1'b0, '0);
		idle_cycles(4);
	endtask

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= max_cycles)
		begin
			$display("Run timed out after %0d cycles", cycle_cnt);
			$display("Test failed");
			$finish;
		end
	end

	initial
	begin
		rst_req = 1'b0;
		lookup_valid = 1'b0;
		lookup_req = '0;
		upd_valid = 1'b0;
		upd = '0;
		test_num = 0;
		done = 1'b0;
		void'($urandom(65));
		@(posedge clk);
		boot_hits();
		miss_lookups();
		random_updates();
		perm_faults();
		back_to_back();
		reset_during_fill();
		done <= 1'b1;
		repeat (2)
			@(posedge clk);
		if (err_cnt == 0 && !u_mmu_top.u_chk.failed)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- tests/mmu_monitor.sv
/* TLB reference model with boot fill, update and lookup pipeline,
   response compare and per-test and closing reports */
`timescale 1ns/100ps

module mmu_monitor
(
	input logic clk,
	input logic rst,
	input logic lookup_valid,
	input mmu_pkg::lookup_req_t lookup_req,
	input logic upd_valid,
	input mmu_pkg::tlb_wr_t upd,
	input logic rsp_valid,
	input mmu_pkg::lookup_rsp_t rsp,
	input logic ready,
	input int test_num,
	input logic done,
	output int err_cnt
);

	mmu_pkg::tlb_entry_t model [128];
	int fill_idx = 128;	// Next boot entry and 128 once the fill is over
	logic exp_v [2];	// Index 1 is due at this edge
	mmu_pkg::lookup_rsp_t exp_rsp [2];
	int cur_test = 0;
	int test_checks = 0;
	int test_errs = 0;
	int tests_run = 0;
	int total_checks = 0;
	logic finished = 1'b0;

	initial
	begin
		err_cnt = 0;
		exp_v[0] = 1'b0;
		exp_v[1] = 1'b0;
	end

	// Entry i of the boot mapping has tag zero, page i minus 63, level 2 and all rights
	function automatic mmu_pkg::tlb_entry_t boot_entry(input int idx);
		mmu_pkg::tlb_entry_t e;
		e = '0;
		e.pte.v = 1'b1;
		e.pte.lvl = 3'd2;
		e.pte.rwx = 3'b111;
		e.pte.ppn = mmu_pkg::ppn_t'(idx - 63);
		return e;
	endfunction

	function automatic mmu_pkg::lookup_rsp_t predict(input mmu_pkg::lookup_req_t req);
		mmu_pkg::tlb_entry_t e;
		mmu_pkg::lookup_rsp_t r;
		logic allowed;
		e = model[req.va[19:13]];
		r = '0;
		r.hit = e.pte.v && (e.tag == req.va[31:20]);
		case (req.acc)
			mmu_pkg::acc_read: allowed = e.pte.rwx[2];
			mmu_pkg::acc_write: allowed = e.pte.rwx[1];
			mmu_pkg::acc_exec: allowed = e.pte.rwx[0];
			default: allowed = 1'b0;
		endcase
		r.fault = r.hit && !allowed;
		if (r.hit)
			r.pa = {e.pte.ppn, req.va[12:0]};
		return r;
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERROR %s in test %0d: got 0x%0h, expected 0x%0h",
				name, cur_test, got, exp);
			err_cnt++;
			test_errs++;
		end
	endtask

	task automatic close_test();
		if (cur_test != 0)
		begin
			$display("Test %0d done: %0d responses checked, %0d errors",
				cur_test, test_checks, test_errs);
			tests_run++;
		end
		test_checks = 0;
		test_errs = 0;
	endtask

	always @(posedge clk)
	begin
		if (test_num != cur_test)
		begin
			close_test();
			cur_test = test_num;
		end
		if (rst)
		begin
			foreach (model[i])
				model[i] = '0;
			fill_idx = 64;
			exp_v[0] = 1'b0;
			exp_v[1] = 1'b0;
		end
		else if (!finished)
		begin
			compare("ready", 32'(ready), 32'(fill_idx == 128));
			compare("rsp_valid", 32'(rsp_valid), 32'(exp_v[1]));
			if (rsp_valid && exp_v[1])
			begin
				compare("rsp.hit", 32'(rsp.hit), 32'(exp_rsp[1].hit));
				compare("rsp.fault", 32'(rsp.fault), 32'(exp_rsp[1].fault));
				compare("rsp.pa", rsp.pa, exp_rsp[1].pa);
				test_checks++;
				total_checks++;
			end
			exp_v[1] = exp_v[0];
			exp_rsp[1] = exp_rsp[0];
			exp_v[0] = lookup_valid;
			if (lookup_valid)
				exp_rsp[0] = predict(lookup_req);	// Entry as it was before this edge
			if (fill_idx < 128)
			begin
				model[fill_idx] = boot_entry(fill_idx);
				fill_idx++;
			end
			else if (upd_valid)
				model[upd.idx] = upd.entry;
		end
		if (done && !finished)
		begin
			close_test();
			$display("Tests run: %0d, responses checked: %0d, errors: %0d",
				tests_run, total_checks, err_cnt);
			finished = 1'b1;
		end
	end

endmodule

//--- tests/mmu_chk.sv
/* Concurrent assertions on response latency, fill state and idle
   response fields, bound into mmu_top */
`timescale 1ns/100ps

module mmu_chk
(
	input logic clk,
	input logic rst,
	input logic lookup_valid,
	input logic rsp_valid,
	input mmu_pkg::lookup_rsp_t rsp,
	input logic fill_we,
	input logic ready
);

	logic latency_bad = 1'b0;
	logic ready_bad = 1'b0;
	logic fill_bad = 1'b0;
	logic idle_bad = 1'b0;
	logic failed;

	assign failed = latency_bad | ready_bad | fill_bad | idle_bad;

	a_rsp_latency: assert property (@(posedge clk) disable iff (rst)
		rsp_valid == $past(lookup_valid, 2))
	else
	begin
		$error("rsp_valid does not follow lookup_valid by two cycles");
		latency_bad = 1'b1;
	end

	// Only a reset may take ready back down
	a_ready_hold: assert property (@(posedge clk) disable iff (rst)
		$past(ready) && !$past(rst) |-> ready)
	else
	begin
		$error("ready fell without a reset");
		ready_bad = 1'b1;
	end

	a_fill_excl: assert property (@(posedge clk) disable iff (rst)
		!(fill_we && ready))
	else
	begin
		$error("fill_we and ready are high together");
		fill_bad = 1'b1;
	end

	a_idle_rsp: assert property (@(posedge clk) disable iff (rst)
		!rsp_valid |-> !rsp.hit && !rsp.fault)
	else
	begin
		$error("hit or fault set without rsp_valid");
		idle_bad = 1'b1;
	end

endmodule

bind mmu_top mmu_chk u_chk
(
	.clk (clk),
	.rst (rst),
	.lookup_valid (lookup_valid),
	.rsp_valid (rsp_valid),
	.rsp (rsp),
	.fill_we (fill_we),
	.ready (ready)
);

//--- tests/tb_clkgen.sv
/* Testbench clock (40 ns period) and reset, held for 8 cycles at start
   and raised again on request */
`timescale 1ns/100ps

module tb_clkgen
(
	input logic rst_req,
	output logic clk,
	output logic rst
);

	logic por = 1'b1;	// Power-on part of the reset

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	initial
	begin
		repeat (8)
			@(posedge clk);
		por <= 1'b0;
	end

	assign rst = por | rst_req;

endmodule

//--- design/mmu_top.sv
/* MMU top level: boot fill machine, TLB entry store and lookup stage */
`timescale 1ns/100ps

module mmu_top
(
	input logic clk,
	input logic rst,
	input logic lookup_valid,
	input mmu_pkg::lookup_req_t lookup_req,
	input logic upd_valid,
	input mmu_pkg::tlb_wr_t upd,
	output logic rsp_valid,
	output mmu_pkg::lookup_rsp_t rsp,
	output logic ready
);

	// Fill machine to store
	logic fill_we;
	mmu_pkg::tlb_wr_t fill_wr;

	// Store to lookup stage, one cycle after the request
	logic rd_valid;
	mmu_pkg::tlb_entry_t rd_entry;
	mmu_pkg::lookup_req_t rd_req;

	tlb_reset_machine u_fill
	(
		.clk (clk),
		.rst (rst),
		.fill_we (fill_we),
		.fill_wr (fill_wr),
		.ready (ready)	// Also gates outside updates
	);

	tlb_ram u_ram
	(
		.clk (clk),
		.rst (rst),
		.fill_we (fill_we),
		.fill_wr (fill_wr),
		.upd_valid (upd_valid),
		.upd (upd),
		.ready (ready),
		.lookup_valid (lookup_valid),
		.lookup_req (lookup_req),
		.rd_valid (rd_valid),
		.rd_entry (rd_entry),
		.rd_req (rd_req)
	);

	// Response leaves two cycles after the request strobe
	tlb_lookup u_lookup
	(
		.clk (clk),
		.rst (rst),
		.rd_valid (rd_valid),
		.rd_entry (rd_entry),
		.rd_req (rd_req),
		.rsp_valid (rsp_valid),
		.rsp (rsp)
	);

endmodule

//--- design/tlb_lookup.sv
/* Lookup stage: tag compare, rights check and physical address forming,
   with a registered response */
`timescale 1ns/100ps

module tlb_lookup
(
	input logic clk,
	input logic rst,
	input logic rd_valid,
	input mmu_pkg::tlb_entry_t rd_entry,
	input mmu_pkg::lookup_req_t rd_req,
	output logic rsp_valid,
	output mmu_pkg::lookup_rsp_t rsp
);

	mmu_pkg::vpn_tag_t req_tag;
	logic [mmu_pkg::log_pagesize-1:0] req_off;
	logic tag_eq;
	logic hit;
	logic right_ok;
	mmu_pkg::pa_t pa;

	// Split the virtual address into tag and page offset
	assign req_tag = rd_req.va[mmu_pkg::va_wid-1 -: mmu_pkg::tag_wid];
	assign req_off = rd_req.va[mmu_pkg::log_pagesize-1:0];

	assign tag_eq = (rd_entry.tag == req_tag);
	assign hit = rd_entry.pte.v & tag_eq;

	// Pick the rights bit for the access kind
	always_comb
	begin
		case (rd_req.acc)
			mmu_pkg::acc_read:
				right_ok = rd_entry.pte.rwx[mmu_pkg::rwx_r];
			mmu_pkg::acc_write:
				right_ok = rd_entry.pte.rwx[mmu_pkg::rwx_w];
			mmu_pkg::acc_exec:
				right_ok = rd_entry.pte.rwx[mmu_pkg::rwx_x];
			default:
				right_ok = 1'b0;	// Unused encoding never has rights
		endcase
	end

	// Page number joined with the offset, nothing on a miss
	always_comb
	begin
		if (hit)
			pa = {rd_entry.pte.ppn, req_off};
		else
			pa = '0;
	end

	// Hit and fault stay low in cycles without a response
	always_ff @(posedge clk)
	begin
		rsp.pa <= pa;
		if (rst)
		begin
			rsp_valid <= 1'b0;
			rsp.hit <= 1'b0;
			rsp.fault <= 1'b0;
		end
		else
		begin
			rsp_valid <= rd_valid;
			rsp.hit <= rd_valid & hit;
			rsp.fault <= rd_valid & hit & ~right_ok;
		end
	end

endmodule

//--- design/tlb_ram.sv
/* Direct-mapped TLB entry store with fill and update write port,
   registered read port and resettable valid bits */
`timescale 1ns/100ps

module tlb_ram
(
	input logic clk,
	input logic rst,
	input logic fill_we,
	input mmu_pkg::tlb_wr_t fill_wr,
	input logic upd_valid,
	input mmu_pkg::tlb_wr_t upd,
	input logic ready,
	input logic lookup_valid,
	input mmu_pkg::lookup_req_t lookup_req,
	output logic rd_valid,
	output mmu_pkg::tlb_entry_t rd_entry,
	output mmu_pkg::lookup_req_t rd_req
);

	mmu_pkg::tlb_entry_t mem [mmu_pkg::tlb_entries];	// Tag and PTE payload
	logic [mmu_pkg::tlb_entries-1:0] valid_bits;

	logic wr_en;
	mmu_pkg::tlb_wr_t wr;
	mmu_pkg::tlb_idx_t rd_idx;
	mmu_pkg::tlb_entry_t rd_word;

	// Fill has priority; updates are only taken once the fill is done
	always_comb
	begin
		if (fill_we)
		begin
			wr = fill_wr;
			wr_en = 1'b1;
		end
		else
		begin
			wr = upd;
			wr_en = upd_valid & ready;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr.idx] <= wr.entry;
	end

	// Valid bits live apart from the array so that reset can clear them
	always_ff @(posedge clk)
	begin
		if (rst)
			valid_bits <= '0;
		else if (wr_en)
			valid_bits[wr.idx] <= wr.entry.pte.v;
	end

	assign rd_idx = lookup_req.va[mmu_pkg::log_pagesize +: mmu_pkg::tlb_wid];

	// Stored valid bit is replaced by the one from the reset array
	always_comb
	begin
		rd_word = mem[rd_idx];
		rd_word.pte.v = valid_bits[rd_idx];
	end

	// Nonblocking read gives the old entry on a same-cycle write
	always_ff @(posedge clk)
	begin
		if (lookup_valid)
		begin
			rd_entry <= rd_word;
			rd_req <= lookup_req;	// Travels beside the entry
		end
		if (rst)
			rd_valid <= 1'b0;
		else
			rd_valid <= lookup_valid;
	end

endmodule

//--- design/tlb_reset_machine.sv
/* Boot fill machine: writes a contiguous mapping into the upper TLB half,
   one entry per cycle after reset */
`timescale 1ns/100ps

module tlb_reset_machine
(
	input logic clk,
	input logic rst,
	output logic fill_we,
	output mmu_pkg::tlb_wr_t fill_wr,
	output logic ready
);

	mmu_pkg::fill_cnt_t fill_cnt;
	mmu_pkg::tlb_entry_t prev_entry;	// Last entry written by the fill
	mmu_pkg::tlb_entry_t next_entry;

	// Counts from fill_base up until the top bit sets
	always_ff @(posedge clk)
	begin
		if (rst)
			fill_cnt <= mmu_pkg::fill_cnt_t'(mmu_pkg::fill_base);
		else if (!fill_cnt[mmu_pkg::tlb_wid])
			fill_cnt <= fill_cnt + 1'b1;
	end

	// Previous entry seeds the next one, starts from all zeros
	always_ff @(posedge clk)
	begin
		if (rst)
			prev_entry <= '0;
		else if (fill_we)
			prev_entry <= next_entry;
	end

	// The tag is carried over unchanged, so it stays zero for the whole fill.
	// The page number steps by one, giving entry i the page i minus 63.
	always_comb
	begin
		next_entry = '0;
		next_entry.tag = prev_entry.tag;
		next_entry.pte.v = 1'b1;
		next_entry.pte.lvl = mmu_pkg::boot_lvl;
		next_entry.pte.rwx = '1;	// Full rights
		next_entry.pte.ppn = prev_entry.pte.ppn + 1'b1;
	end

	always_comb
	begin
		fill_wr.idx = fill_cnt[mmu_pkg::tlb_wid-1:0];
		fill_wr.entry = next_entry;
	end

	assign ready = fill_cnt[mmu_pkg::tlb_wid];	// Set after entry 127
	assign fill_we = ~fill_cnt[mmu_pkg::tlb_wid];

endmodule

//--- design/mmu_pkg.sv
/* Widths, typedefs, access kinds and entry, write, request and response
   structs of the MMU translation block */

package mmu_pkg;

	// TLB geometry
	localparam int tlb_entries = 128;
	localparam int tlb_wid = 7;	// Index width, log2 of tlb_entries
	localparam int log_pagesize = 13;	// 8 KB pages
	localparam int fill_base = 64;	// First entry of the boot mapping

	// Address widths
	localparam int va_wid = 32;
	localparam int pa_wid = 32;
	localparam int tag_wid = va_wid - tlb_wid - log_pagesize;	// 12
	localparam int ppn_wid = pa_wid - log_pagesize;	// 19

	// Bit positions inside the rights field
	localparam int rwx_r = 2;
	localparam int rwx_w = 1;
	localparam int rwx_x = 0;

	// Level written by the boot fill
	localparam logic [2:0] boot_lvl = 3'd2;

	typedef logic [va_wid-1:0] va_t;
	typedef logic [pa_wid-1:0] pa_t;
	typedef logic [tlb_wid-1:0] tlb_idx_t;	// VA bits 13 to 19
	typedef logic [tag_wid-1:0] vpn_tag_t;	// VA bits 20 to 31
	typedef logic [ppn_wid-1:0] ppn_t;
	typedef logic [2:0] rwx_t;	// Read high, write middle, execute low
	typedef logic [2:0] lvl_t;

	// Fill counter, one bit wider than the index so the top bit marks the end
	typedef logic [tlb_wid:0] fill_cnt_t;

	// Kind of access that a lookup checks against the rights
	typedef enum logic [1:0]
	{
		acc_read = 2'd0,
		acc_write = 2'd1,
		acc_exec = 2'd2
	} access_t;

	typedef struct packed
	{
		logic v;
		lvl_t lvl;
		rwx_t rwx;
		ppn_t ppn;
	} pte_t;

	typedef struct packed
	{
		vpn_tag_t tag;
		pte_t pte;
	} tlb_entry_t;

	// One write into the entry store
	typedef struct packed
	{
		tlb_idx_t idx;
		tlb_entry_t entry;
	} tlb_wr_t;

	typedef struct packed
	{
		va_t va;
		access_t acc;
	} lookup_req_t;

	typedef struct packed
	{
		logic hit;
		logic fault;	// Hit without the right for the access kind
		pa_t pa;	// Zero on a miss
	} lookup_rsp_t;

endpackage
